/* common/pr_ctrl_pkg.sv */
// region control types; the persona id is fixed at build time and is not host-writable
package pr_ctrl_pkg;

   // handshake controller states, two bits
   typedef enum logic [1:0] {
      hs_run      = 2'd0,   // region live, commands accepted
      hs_draining = 2'd1,   // freeze up, waiting for reads in flight
      hs_stopped  = 2'd2    // quiet, safe to reconfigure
   } hs_state_e;

   // "hpra" in ascii
   localparam logic [31:0] PERSONA_ID = 32'h6870_7261;

endpackage : pr_ctrl_pkg

/* common/pr_csr_pkg.sv */
// register map of the persona; offsets are word addresses (byte address / 4), no bursts
package pr_csr_pkg;

   localparam int unsigned ADDR_W = 16;           // avalon byte address
   localparam int unsigned DATA_W = 32;
   localparam int unsigned BE_W   = DATA_W / 8;   // one enable per byte lane
   localparam int unsigned WORD_W = ADDR_W - 2;   // byte address without the two lane bits

   typedef logic [WORD_W-1:0] word_addr_t;

   // word offsets
   localparam word_addr_t REG_ID          = word_addr_t'(16'h0000 >> 2);  // read only
   localparam word_addr_t REG_ACC_OPERAND = word_addr_t'(16'h0008 >> 2);  // write runs the op
   localparam word_addr_t REG_ACC_CTRL    = word_addr_t'(16'h000C >> 2);  // opcode in [1:0]
   localparam word_addr_t REG_ACC_RESULT  = word_addr_t'(16'h0010 >> 2);  // read only
   localparam word_addr_t REG_OP_COUNT    = word_addr_t'(16'h0014 >> 2);  // read only
   localparam word_addr_t SCRATCH_BASE    = word_addr_t'(16'h0040 >> 2);  // word i at base + i

   // accumulator opcode
   typedef enum logic [1:0] {
      acc_load  = 2'd0,   // result = operand
      acc_add   = 2'd1,   // result = result + operand, wraps
      acc_xor   = 2'd2,   // result = result ^ operand
      acc_clear = 2'd3    // result = 0, operand unused
   } acc_op_e;

endpackage : pr_csr_pkg

/* common/csr_bus_if.sv */
// internal register bus; wr/rd are single-cycle strobes, rdata is valid the edge after rd
interface csr_bus_if;

   logic                            wr;         // write strobe, one cycle
   logic                            rd;         // read strobe, one cycle
   logic [pr_csr_pkg::WORD_W-1:0]   word_addr;  // word address, lane bits dropped
   logic [pr_csr_pkg::DATA_W-1:0]   wdata;
   logic [pr_csr_pkg::BE_W-1:0]     be;         // byte lane enables
   logic [pr_csr_pkg::DATA_W-1:0]   rdata;      // registered by the slave

   // bridge side
   modport master (
      output wr,
      output rd,
      output word_addr,
      output wdata,
      output be,
      input  rdata
   );

   // register block side
   modport slave (
      input  wr,
      input  rd,
      input  word_addr,
      input  wdata,
      input  be,
      output rdata
   );

endinterface : csr_bus_if

/* pr_handshake/pr_handshake_ctrl.sv */
// start/stop handshake; stop acts on the rising edge of stop_req, start needs stop_req low
module pr_handshake_ctrl (
   input  logic pr_region_clk,
   input  logic rst_n,
   input  logic start_req,
   input  logic stop_req,
   input  logic rd_pending,   // a read accepted but no readdatavalid yet
   output logic start_ack,
   output logic stop_ack,
   output logic freeze
);

   pr_ctrl_pkg::hs_state_e state;
   pr_ctrl_pkg::hs_state_e state_nxt;
   logic                   stop_req_q;   // previous stop_req for edge detect
   logic                   stop_rise;
   logic                   start_seen;   // restart done, ack held until start_req falls

   assign stop_rise = stop_req & ~stop_req_q;

   always_comb begin
      state_nxt = state;
      case (state)
         pr_ctrl_pkg::hs_run: begin
            if (stop_rise) begin
               state_nxt = pr_ctrl_pkg::hs_draining;
            end
         end
         pr_ctrl_pkg::hs_draining: begin
            // stay at least one cycle, leave once reads have returned
            if (!rd_pending) begin
               state_nxt = pr_ctrl_pkg::hs_stopped;
            end
         end
         pr_ctrl_pkg::hs_stopped: begin
            if (start_req && !stop_req) begin
               state_nxt = pr_ctrl_pkg::hs_run;
            end
         end
         default: state_nxt = pr_ctrl_pkg::hs_run;   // unused encoding
      endcase
   end

   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         state      <= pr_ctrl_pkg::hs_run;
         stop_req_q <= 1'b0;
         start_seen <= 1'b0;
      end else begin
         state      <= state_nxt;
         stop_req_q <= stop_req;
         if (!start_req) begin
            start_seen <= 1'b0;
         end else if (state == pr_ctrl_pkg::hs_stopped &&
                      state_nxt == pr_ctrl_pkg::hs_run) begin
            start_seen <= 1'b1;   // set on the stopped -> run edge
         end
      end
   end

   assign freeze    = (state != pr_ctrl_pkg::hs_run);   // draining and stopped
   assign stop_ack  = (state == pr_ctrl_pkg::hs_stopped) & stop_req;
   assign start_ack = start_seen & start_req;           // drops with start_req

endmodule : pr_handshake_ctrl

/* avmm_bridge/avmm_csr_bridge.sv */
// avalon-mm slave, single beat only; writes with burstcount other than 1 are dropped
module avmm_csr_bridge (
   input  logic                          pr_region_clk,
   input  logic                          rst_n,
   input  logic [pr_csr_pkg::ADDR_W-1:0] avmm_address,
   input  logic [pr_csr_pkg::DATA_W-1:0] avmm_writedata,
   input  logic [pr_csr_pkg::BE_W-1:0]   avmm_byteenable,
   input  logic [0:0]                    avmm_burstcount,
   input  logic                          avmm_read,
   input  logic                          avmm_write,
   output logic                          avmm_waitrequest,
   output logic [pr_csr_pkg::DATA_W-1:0] avmm_readdata,
   output logic                          avmm_readdatavalid,
   input  logic                          freeze,
   output logic                          rd_pending,
   csr_bus_if.master                     csr
);

   logic accept_rd;    // read taken on this edge
   logic accept_wr;    // write taken on this edge
   logic burst_ok;
   logic rd_stage;     // read sits in the register block for one cycle

   // freeze is the only source of back-pressure
   assign avmm_waitrequest = freeze;

   assign accept_rd = avmm_read  & ~freeze;
   assign accept_wr = avmm_write & ~freeze;
   assign burst_ok  = (avmm_burstcount == 1'b1);

   // strobes go out in the accept cycle, so a write lands on the accept edge
   assign csr.wr        = accept_wr & burst_ok;
   assign csr.rd        = accept_rd;   // reads always return one beat
   assign csr.word_addr = avmm_address[pr_csr_pkg::ADDR_W-1:2];   // drop lane bits
   assign csr.wdata     = avmm_writedata;
   assign csr.be        = avmm_byteenable;

   // read return pipeline
   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         rd_stage           <= 1'b0;
         avmm_readdatavalid <= 1'b0;
      end else begin
         rd_stage           <= accept_rd;
         avmm_readdatavalid <= rd_stage;   // one cycle after the block registered rdata
      end
   end

   always_ff @(posedge pr_region_clk) begin
      if (rd_stage) begin
         avmm_readdata <= csr.rdata;
      end
   end

   // pending from accept until readdatavalid is driven
   assign rd_pending = rd_stage;

endmodule : avmm_csr_bridge

/* persona_regs/persona_csr_block.sv */
// persona registers; byte enables apply to the scratch bank only, NUM_SCRATCH is 1 to 16
module persona_csr_block #(
   parameter int unsigned NUM_SCRATCH = 4
) (
   input  logic     pr_region_clk,
   input  logic     rst_n,
   csr_bus_if.slave csr
);

   localparam int unsigned IDX_W = (NUM_SCRATCH > 1) ? $clog2(NUM_SCRATCH) : 1;

   logic [pr_csr_pkg::DATA_W-1:0] scratch [NUM_SCRATCH];
   logic                          scratch_hit;   // word_addr falls in the bank
   logic [pr_csr_pkg::WORD_W-1:0] scratch_off;
   logic [IDX_W-1:0]              scratch_idx;

   pr_csr_pkg::acc_op_e           acc_op;        // opcode register
   pr_csr_pkg::acc_op_e           op_q;          // opcode latched with the operand
   logic [pr_csr_pkg::DATA_W-1:0] operand_q;
   logic                          acc_go;        // pipeline stage valid
   logic [pr_csr_pkg::DATA_W-1:0] acc_result;
   logic [pr_csr_pkg::DATA_W-1:0] acc_next;
   logic [pr_csr_pkg::DATA_W-1:0] op_count;

   logic [pr_csr_pkg::DATA_W-1:0] rd_mux;

   // scratch decode
   assign scratch_off = csr.word_addr - pr_csr_pkg::SCRATCH_BASE;
   assign scratch_hit = (csr.word_addr >= pr_csr_pkg::SCRATCH_BASE) &&
                        (scratch_off < pr_csr_pkg::WORD_W'(NUM_SCRATCH));
   assign scratch_idx = scratch_off[IDX_W-1:0];

   // scratch bank, merged per byte lane
   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_SCRATCH; i++) begin
            scratch[i] <= '0;   // known start for partial writes
         end
      end else if (csr.wr && scratch_hit) begin
         for (int b = 0; b < pr_csr_pkg::BE_W; b++) begin
            if (csr.be[b]) begin
               scratch[scratch_idx][8*b +: 8] <= csr.wdata[8*b +: 8];
            end
         end
      end
   end

   // opcode register and operand capture
   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         acc_op <= pr_csr_pkg::acc_load;
         acc_go <= 1'b0;
      end else begin
         acc_go <= csr.wr && (csr.word_addr == pr_csr_pkg::REG_ACC_OPERAND);
         if (csr.wr && csr.word_addr == pr_csr_pkg::REG_ACC_CTRL) begin
            acc_op <= pr_csr_pkg::acc_op_e'(csr.wdata[1:0]);
         end
      end
   end

   always_ff @(posedge pr_region_clk) begin
      if (csr.wr && csr.word_addr == pr_csr_pkg::REG_ACC_OPERAND) begin
         operand_q <= csr.wdata;
         op_q      <= acc_op;   // opcode in force at the operand write
      end
   end

   // accumulator function
   always_comb begin
      case (op_q)
         pr_csr_pkg::acc_load:  acc_next = operand_q;
         pr_csr_pkg::acc_add:   acc_next = acc_result + operand_q;   // wraps mod 2^32
         pr_csr_pkg::acc_xor:   acc_next = acc_result ^ operand_q;
         pr_csr_pkg::acc_clear: acc_next = '0;
         default:               acc_next = acc_result;
      endcase
   end

   // result and counter update one edge after the operand write
   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         acc_result <= '0;
         op_count   <= '0;
      end else if (acc_go) begin
         acc_result <= acc_next;
         op_count   <= op_count + 1'b1;
      end
   end

   // read decode, unmapped words read zero
   always_comb begin
      rd_mux = '0;
      if (scratch_hit) begin
         rd_mux = scratch[scratch_idx];
      end else begin
         case (csr.word_addr)
            pr_csr_pkg::REG_ID:          rd_mux = pr_ctrl_pkg::PERSONA_ID;
            pr_csr_pkg::REG_ACC_OPERAND: rd_mux = operand_q;
            pr_csr_pkg::REG_ACC_CTRL:    rd_mux = {{(pr_csr_pkg::DATA_W-2){1'b0}}, acc_op};
            pr_csr_pkg::REG_ACC_RESULT:  rd_mux = acc_result;
            pr_csr_pkg::REG_OP_COUNT:    rd_mux = op_count;
            default:                     rd_mux = '0;
         endcase
      end
   end

   always_ff @(posedge pr_region_clk) begin
      if (csr.rd) begin
         csr.rdata <= rd_mux;   // valid on the edge after the strobe
      end
   end

endmodule : persona_csr_block

/* src/parent_persona_top.sv */
// static side of one pr region; single-beat avalon-mm, burstcount must be 1
module parent_persona_top #(
   parameter int unsigned NUM_SCRATCH = 4   // scratch words, 1 to 16
) (
   input  logic                          pr_region_clk,
   input  logic                          rst_n,

   // handshake with the host
   input  logic                          pr_handshake_start_req,
   output logic                          pr_handshake_start_ack,
   input  logic                          pr_handshake_stop_req,
   output logic                          pr_handshake_stop_ack,
   output logic                          freeze_pr_region_avmm,

   // avalon-mm slave
   output logic                          pr_region_avmm_waitrequest,
   output logic [pr_csr_pkg::DATA_W-1:0] pr_region_avmm_readdata,
   output logic                          pr_region_avmm_readdatavalid,
   input  logic [0:0]                    pr_region_avmm_burstcount,
   input  logic [pr_csr_pkg::DATA_W-1:0] pr_region_avmm_writedata,
   input  logic [pr_csr_pkg::ADDR_W-1:0] pr_region_avmm_address,
   input  logic                          pr_region_avmm_write,
   input  logic                          pr_region_avmm_read,
   input  logic [pr_csr_pkg::BE_W-1:0]   pr_region_avmm_byteenable
);

   logic rd_pending;   // bridge -> controller
   logic freeze;       // controller -> bridge and host

   csr_bus_if u_csr_bus ();

   pr_handshake_ctrl u_hs_ctrl (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .start_req     (pr_handshake_start_req),
      .stop_req      (pr_handshake_stop_req),
      .rd_pending    (rd_pending),
      .start_ack     (pr_handshake_start_ack),
      .stop_ack      (pr_handshake_stop_ack),
      .freeze        (freeze)
   );

   avmm_csr_bridge u_bridge (
      .pr_region_clk      (pr_region_clk),
      .rst_n              (rst_n),
      .avmm_address       (pr_region_avmm_address),
      .avmm_writedata     (pr_region_avmm_writedata),
      .avmm_byteenable    (pr_region_avmm_byteenable),
      .avmm_burstcount    (pr_region_avmm_burstcount),
      .avmm_read          (pr_region_avmm_read),
      .avmm_write         (pr_region_avmm_write),
      .avmm_waitrequest   (pr_region_avmm_waitrequest),
      .avmm_readdata      (pr_region_avmm_readdata),
      .avmm_readdatavalid (pr_region_avmm_readdatavalid),
      .freeze             (freeze),
      .rd_pending         (rd_pending),
      .csr                (u_csr_bus.master)
   );

   persona_csr_block #(
      .NUM_SCRATCH (NUM_SCRATCH)
   ) u_regs (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .csr           (u_csr_bus.slave)
   );

   assign freeze_pr_region_avmm = freeze;

endmodule : parent_persona_top

/* bench/persona_checker.sv */
// monitor of the top ports, sampled at the rising edge; single-beat host, NUM_SCRATCH <= 16
module persona_checker #(
   parameter int unsigned NUM_SCRATCH = 4
) (
   input logic                          pr_region_clk,
   input logic                          rst_n,
   input logic                          start_req,
   input logic                          start_ack,
   input logic                          stop_req,
   input logic                          stop_ack,
   input logic                          freeze,
   input logic                          waitrequest,
   input logic [pr_csr_pkg::DATA_W-1:0] readdata,
   input logic                          readdatavalid,
   input logic [pr_csr_pkg::ADDR_W-1:0] address,
   input logic [pr_csr_pkg::DATA_W-1:0] writedata,
   input logic [pr_csr_pkg::BE_W-1:0]   byteenable,
   input logic [0:0]                    burstcount,
   input logic                          read,
   input logic                          write
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned            val_errs  = 0;
   int unsigned            rule_errs = 0;
   logic [31:0]            model_q [$];       // predicted data, one per accepted read
   logic [31:0]            table_q [$];       // expected column pushed by the testbench
   logic [31:0]            scratch_m [16];
   logic [31:0]            result_m;
   logic [31:0]            count_m;
   logic [31:0]            operand_m;
   pr_csr_pkg::acc_op_e    op_m;              // opcode register
   pr_csr_pkg::acc_op_e    op_p;              // opcode taken with the last operand
   logic                   acc_pend;          // operand written, result due next edge
   pr_ctrl_pkg::hs_state_e hs_m;              // expected controller state
   logic                   start_seen_m;
   logic                   stop_req_d;
   logic                   rd_acc_d;          // read accepted at the previous edge
   logic                   rd_acc_dd;         // read accepted two edges back, its beat is due now
   logic                   stop_ack_d;
   logic                   after_rst = 1'b0;
   int                     stop_since;        // edges since stop_req rose

   task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
      val_errs++;
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, sig, exp, act);
   endtask

   task automatic rule_error(input string what);
      rule_errs++;
      $display("[ERROR] %0d ns %s", $time, what);
   endtask

   task automatic expect_bit(input string sig, input logic exp, input logic act);
      if (act !== exp) begin
         value_error($sformatf("%s (model %s)", sig, hs_m.name()), 32'(exp), 32'(act));
      end
   endtask

   // called by the testbench at the accept edge of each read
   task automatic expect_read(input logic [31:0] value);
      table_q.push_back(value);
   endtask

   task automatic check_drained();
      if (model_q.size() != 0) begin
         rule_error($sformatf("%0d accepted reads never returned readdatavalid", model_q.size()));
      end
   endtask

   function automatic bit in_scratch(input logic [pr_csr_pkg::WORD_W-1:0] w);
      return (w >= pr_csr_pkg::SCRATCH_BASE) && (w < pr_csr_pkg::SCRATCH_BASE + NUM_SCRATCH);
   endfunction

   // register map as seen by a read
   function automatic logic [31:0] predict(input logic [pr_csr_pkg::WORD_W-1:0] w);
      if (in_scratch(w)) begin
         return scratch_m[w - pr_csr_pkg::SCRATCH_BASE];
      end
      case (w)
         pr_csr_pkg::REG_ID:          return pr_ctrl_pkg::PERSONA_ID;
         pr_csr_pkg::REG_ACC_OPERAND: return operand_m;
         pr_csr_pkg::REG_ACC_CTRL:    return {30'd0, op_m};
         pr_csr_pkg::REG_ACC_RESULT:  return result_m;
         pr_csr_pkg::REG_OP_COUNT:    return count_m;
         default:                     return 32'd0;   // unmapped
      endcase
   endfunction

   always @(posedge pr_region_clk) begin : sample_edge
      logic                          rd_acc;
      logic                          wr_acc;
      logic [pr_csr_pkg::WORD_W-1:0] w;
      rd_acc = read & ~waitrequest;
      wr_acc = write & ~waitrequest & (burstcount == 1'b1);
      w      = address[pr_csr_pkg::ADDR_W-1:2];
      if (!rst_n) begin
         foreach (scratch_m[i]) scratch_m[i] = '0;
         result_m     = '0;
         count_m      = '0;
         operand_m    = '0;
         op_m         = pr_csr_pkg::acc_load;
         acc_pend     = 1'b0;
         hs_m         = pr_ctrl_pkg::hs_run;
         start_seen_m = 1'b0;
         stop_req_d   = 1'b0;
         stop_ack_d   = 1'b0;
         rd_acc_d     = 1'b0;
         rd_acc_dd    = 1'b0;
         stop_since   = 0;
         model_q.delete();
         after_rst    = 1'b1;
      end else begin
         if (after_rst) begin   // first edge out of reset, everything idle
            expect_bit("pr_region_avmm_waitrequest", 1'b0, waitrequest);
            expect_bit("pr_region_avmm_readdatavalid", 1'b0, readdatavalid);
            expect_bit("pr_handshake_start_ack", 1'b0, start_ack);
            expect_bit("pr_handshake_stop_ack", 1'b0, stop_ack);
            expect_bit("freeze_pr_region_avmm", 1'b0, freeze);
         end else begin
            expect_bit("freeze_pr_region_avmm", hs_m != pr_ctrl_pkg::hs_run, freeze);
            expect_bit("pr_region_avmm_waitrequest", hs_m != pr_ctrl_pkg::hs_run, waitrequest);
            expect_bit("pr_handshake_stop_ack", (hs_m == pr_ctrl_pkg::hs_stopped) && stop_req,
                       stop_ack);
            expect_bit("pr_handshake_start_ack", start_seen_m && start_req, start_ack);
            // beat is high for exactly the cycle after accept edge plus one
            expect_bit("pr_region_avmm_readdatavalid", rd_acc_dd, readdatavalid);
         end
         after_rst = 1'b0;

         // one beat per accepted read, in order
         if (readdatavalid === 1'b1) begin
            if (model_q.size() == 0) begin
               rule_error("readdatavalid seen with no read outstanding");
            end else begin
               logic [31:0] exp_v;
               exp_v = model_q.pop_front();
               if (readdata !== exp_v) value_error("pr_region_avmm_readdata", exp_v, readdata);
            end
            if (table_q.size() == 0) begin
               rule_error("read returned with no expected value from the stimulus table");
            end else begin
               logic [31:0] tbl_v;
               tbl_v = table_q.pop_front();
               if (readdata !== tbl_v) begin
                  value_error("pr_region_avmm_readdata (table)", tbl_v, readdata);
               end
            end
         end

         if (stop_ack && !stop_ack_d) begin
            if (model_q.size() != 0) begin
               rule_error("stop_ack rose while a read was still outstanding");
            end
            if (stop_since < 2 || stop_since > 3) begin
               rule_error($sformatf("stop_ack rose %0d cycles after stop_req, not 2 or 3",
                                    stop_since));
            end
         end
         stop_since++;

         // controller progress from the values before this edge
         case (hs_m)
            pr_ctrl_pkg::hs_run: begin
               if (stop_req && !stop_req_d) begin
                  hs_m       = pr_ctrl_pkg::hs_draining;
                  stop_since = 1;
               end
            end
            pr_ctrl_pkg::hs_draining: if (!rd_acc_d) hs_m = pr_ctrl_pkg::hs_stopped;
            default: begin
               if (start_req && !stop_req) begin
                  hs_m         = pr_ctrl_pkg::hs_run;
                  start_seen_m = 1'b1;
               end
            end
         endcase
         if (!start_req) start_seen_m = 1'b0;

         if (rd_acc) model_q.push_back(predict(w));   // sees writes from earlier edges only
         if (acc_pend) begin   // result lands one edge after the operand
            case (op_p)
               pr_csr_pkg::acc_load: result_m = operand_m;
               pr_csr_pkg::acc_add:  result_m = result_m + operand_m;
               pr_csr_pkg::acc_xor:  result_m = result_m ^ operand_m;
               default:              result_m = '0;
            endcase
            count_m++;
            acc_pend = 1'b0;
         end
         if (wr_acc) begin
            if (in_scratch(w)) begin
               for (int b = 0; b < 4; b++) begin
                  if (byteenable[b]) begin
                     scratch_m[w - pr_csr_pkg::SCRATCH_BASE][8*b +: 8] = writedata[8*b +: 8];
                  end
               end
            end else if (w == pr_csr_pkg::REG_ACC_CTRL) begin
               op_m = pr_csr_pkg::acc_op_e'(writedata[1:0]);
            end else if (w == pr_csr_pkg::REG_ACC_OPERAND) begin
               operand_m = writedata;
               op_p      = op_m;
               acc_pend  = 1'b1;
            end
         end
         rd_acc_dd  = rd_acc_d;
         rd_acc_d   = rd_acc;
         stop_req_d = stop_req;
         stop_ack_d = stop_ack;
      end
   end

endmodule : persona_checker

/* bench/tb_parent_persona.sv */
// table-driven host for parent_persona_top; single-beat avalon, held write rides on the start row
module tb_parent_persona;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned NUM_SCRATCH = 4;
   localparam logic [31:0] HOST_ID     = 32'h6870_7261;   // persona id the host looks for

   typedef enum {row_write, row_read, row_stop, row_start, row_idle} row_kind_e;
   typedef struct {
      row_kind_e   kind;
      logic [15:0] addr;
      logic [31:0] data;
      logic [3:0]  be;
      logic [31:0] exp;   // expected read value, reads and stop rows only
   } row_t;

   logic        pr_region_clk = 1'b0;
   logic        rst_n;
   logic        start_req;
   logic        stop_req;
   logic        start_ack;
   logic        stop_ack;
   logic        freeze;
   logic        waitrequest;
   logic [31:0] readdata;
   logic        readdatavalid;
   logic [0:0]  burstcount;
   logic [31:0] writedata;
   logic [15:0] address;
   logic        write;
   logic        read;
   logic [3:0]  byteenable;

   row_t        rows [$];
   int unsigned n_rows = 0;
   logic [31:0] shadow [16];   // scratch contents as the table expects them
   int unsigned total_errs;

   always #10 pr_region_clk = ~pr_region_clk;   // 20 ns period

   parent_persona_top #(.NUM_SCRATCH(NUM_SCRATCH)) uut (
      .pr_region_clk(pr_region_clk), .rst_n(rst_n),
      .pr_handshake_start_req(start_req), .pr_handshake_start_ack(start_ack),
      .pr_handshake_stop_req(stop_req), .pr_handshake_stop_ack(stop_ack),
      .freeze_pr_region_avmm(freeze),
      .pr_region_avmm_waitrequest(waitrequest), .pr_region_avmm_readdata(readdata),
      .pr_region_avmm_readdatavalid(readdatavalid), .pr_region_avmm_burstcount(burstcount),
      .pr_region_avmm_writedata(writedata), .pr_region_avmm_address(address),
      .pr_region_avmm_write(write), .pr_region_avmm_read(read),
      .pr_region_avmm_byteenable(byteenable)
   );

   persona_checker #(.NUM_SCRATCH(NUM_SCRATCH)) chk (
      .pr_region_clk(pr_region_clk), .rst_n(rst_n),
      .start_req(start_req), .start_ack(start_ack), .stop_req(stop_req), .stop_ack(stop_ack),
      .freeze(freeze), .waitrequest(waitrequest), .readdata(readdata),
      .readdatavalid(readdatavalid), .address(address), .writedata(writedata),
      .byteenable(byteenable), .burstcount(burstcount), .read(read), .write(write)
   );

   function automatic logic [15:0] byte_addr(input logic [13:0] word);
      return {word, 2'b00};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                               input logic [3:0] be);
      logic [31:0] m;
      m = old;
      for (int b = 0; b < 4; b++) if (be[b]) m[8*b +: 8] = nw[8*b +: 8];
      return m;
   endfunction

   task automatic add_row(input row_kind_e k, input logic [15:0] a, input logic [31:0] d,
                          input logic [3:0] be, input logic [31:0] exp);
      rows.push_back('{kind: k, addr: a, data: d, be: be, exp: exp});
   endtask

   task automatic build_table();
      pr_csr_pkg::acc_op_e ops [5];
      logic [31:0]         opnd [5];
      logic [31:0]         acc;
      logic [31:0]         nxt;
      logic [31:0]         val;
      logic [3:0]          be;
      ops  = '{pr_csr_pkg::acc_load, pr_csr_pkg::acc_add, pr_csr_pkg::acc_xor,
               pr_csr_pkg::acc_add, pr_csr_pkg::acc_clear};
      opnd = '{32'h1234_5678, 32'h0F0F_0F0F, 32'hFFFF_0000, 32'hFFFF_FFF0, 32'hDEAD_BEEF};
      acc  = 32'd0;
      foreach (shadow[i]) shadow[i] = 32'd0;
      // id, and a write that must not stick
      add_row(row_read, byte_addr(pr_csr_pkg::REG_ID), 0, 4'hF, HOST_ID);
      add_row(row_write, byte_addr(pr_csr_pkg::REG_ID), 32'hDEAD_BEEF, 4'hF, 0);
      add_row(row_read, byte_addr(pr_csr_pkg::REG_ID), 0, 4'hF, HOST_ID);
      // scratch: full word, then a random partial merge
      for (int i = 0; i < NUM_SCRATCH; i++) begin
         val = $urandom();
         add_row(row_write, byte_addr(pr_csr_pkg::SCRATCH_BASE + 14'(i)), val, 4'hF, 0);
         shadow[i] = val;
         val = $urandom();
         be  = 4'($urandom());
         add_row(row_write, byte_addr(pr_csr_pkg::SCRATCH_BASE + 14'(i)), val, be, 0);
         shadow[i] = merge_bytes(shadow[i], val, be);
      end
      for (int i = 0; i < NUM_SCRATCH; i++) begin   // back to back
         add_row(row_read, byte_addr(pr_csr_pkg::SCRATCH_BASE + 14'(i)), 0, 4'hF, shadow[i]);
      end
      add_row(row_read, 16'h0004, 0, 4'hF, 0);   // hole in the map
      add_row(row_read, 16'h0100, 0, 4'hF, 0);
      // accumulator, result read right after the operand still shows the old value
      for (int i = 0; i < 5; i++) begin
         case (ops[i])
            pr_csr_pkg::acc_load: nxt = opnd[i];
            pr_csr_pkg::acc_add:  nxt = acc + opnd[i];   // 32-bit wrap
            pr_csr_pkg::acc_xor:  nxt = acc ^ opnd[i];
            default:              nxt = 32'd0;
         endcase
         add_row(row_write, byte_addr(pr_csr_pkg::REG_ACC_CTRL), 32'(ops[i]), 4'hF, 0);
         add_row(row_write, byte_addr(pr_csr_pkg::REG_ACC_OPERAND), opnd[i], 4'hF, 0);
         add_row(row_read, byte_addr(pr_csr_pkg::REG_ACC_RESULT), 0, 4'hF, acc);
         add_row(row_read, byte_addr(pr_csr_pkg::REG_ACC_RESULT), 0, 4'hF, nxt);
         acc = nxt;
      end
      add_row(row_idle, 0, 0, 0, 0);
      add_row(row_idle, 0, 0, 0, 0);
      add_row(row_read, byte_addr(pr_csr_pkg::REG_OP_COUNT), 0, 4'hF, 32'd5);
      // stop with a read in flight, then restart with a write held across the stop
      add_row(row_stop, byte_addr(pr_csr_pkg::SCRATCH_BASE), 0, 4'hF, shadow[0]);
      val = $urandom();
      add_row(row_start, byte_addr(pr_csr_pkg::SCRATCH_BASE + 14'(NUM_SCRATCH - 1)), val, 4'hF, 0);
      shadow[NUM_SCRATCH-1] = val;
      add_row(row_read, byte_addr(pr_csr_pkg::SCRATCH_BASE + 14'(NUM_SCRATCH - 1)), 0, 4'hF,
              shadow[NUM_SCRATCH-1]);
      add_row(row_read, byte_addr(pr_csr_pkg::REG_ID), 0, 4'hF, HOST_ID);
   endtask

   task automatic wait_accept();
      do @(posedge pr_region_clk); while (waitrequest);   // pre-edge waitrequest
   endtask

   task automatic issue_cmd(input row_t r);
      address    <= r.addr;
      writedata  <= r.data;
      byteenable <= r.be;
      read       <= (r.kind == row_read);
      write      <= (r.kind == row_write);
      wait_accept();
      if (r.kind == row_read) chk.expect_read(r.exp);
   endtask

   task automatic stop_during_read(input row_t r);
      stop_req   <= 1'b1;   // read goes out on the same edge, still pending while draining
      address    <= r.addr;
      byteenable <= r.be;
      read       <= 1'b1;
      write      <= 1'b0;
      wait_accept();
      chk.expect_read(r.exp);
      read <= 1'b0;
      do @(posedge pr_region_clk); while (!stop_ack);
      stop_req <= 1'b0;
   endtask

   task automatic start_with_held_write(input row_t r);
      address    <= r.addr;
      writedata  <= r.data;
      byteenable <= r.be;
      read       <= 1'b0;
      write      <= 1'b1;
      repeat (3) @(posedge pr_region_clk);   // write parked behind waitrequest
      start_req <= 1'b1;
      wait_accept();
      start_req <= 1'b0;
   endtask

   task automatic apply_row(input row_t r);
      case (r.kind)
         row_write, row_read: issue_cmd(r);
         row_stop:            stop_during_read(r);
         row_start:           start_with_held_write(r);
         default: begin
            read  <= 1'b0;
            write <= 1'b0;
            @(posedge pr_region_clk);
         end
      endcase
   endtask

   initial begin
      rst_n      = 1'b0;
      start_req  = 1'b0;
      stop_req   = 1'b0;
      burstcount = 1'b1;   // single beat only
      writedata  = '0;
      address    = '0;
      write      = 1'b0;
      read       = 1'b0;
      byteenable = '0;
      void'($urandom(32'hcb7e));
      build_table();
      n_rows = rows.size();
      repeat (2) @(posedge pr_region_clk);
      rst_n <= 1'b1;
      foreach (rows[i]) apply_row(rows[i]);
      read  <= 1'b0;
      write <= 1'b0;
      repeat (4) @(posedge pr_region_clk);   // let the last beats come back
      chk.check_drained();
      total_errs = chk.val_errs + chk.rule_errs;
      $display("value errors %0d, protocol errors %0d", chk.val_errs, chk.rule_errs);
      if (total_errs == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // watchdog, 20 cycles per row plus margin
   initial begin
      wait (n_rows != 0);
      #(n_rows * 400 + 1000);
      $display("timeout, the table did not complete in %0d ns", n_rows * 400 + 1000);
      $display("Verification failed");
      $finish;
   end

endmodule : tb_parent_persona

/* parent_persona.f */
common/pr_ctrl_pkg.sv
common/pr_csr_pkg.sv
common/csr_bus_if.sv
pr_handshake/pr_handshake_ctrl.sv
avmm_bridge/avmm_csr_bridge.sv
persona_regs/persona_csr_block.sv
src/parent_persona_top.sv
bench/persona_checker.sv
bench/tb_parent_persona.sv
